//--- apple1_pkg.sv
// Bus types and the fixed Apple-1 address map; BASIC ROM and PS/2 ranges are not mapped
package apple1_pkg;

    ////////////////////
    // Bus transfer types
    ////////////////////

    // One request on the shared bus, 25 bits
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } bus_req_t;

    // Read reply, valid travels beside it
    typedef struct packed {
        logic [7:0] rdata;
    } bus_rsp_t;

    // Flag is rx_ready on KBDCR, tx_busy on DSP
    typedef struct packed {
        logic       flag;
        logic [6:0] reserved;
    } uart_status_t;

    // UART read word, a byte on KBD and flags on the control registers
    typedef union packed {
        logic [7:0]   data;
        uart_status_t status;
    } uart_rdata_u;

    ////////////////////
    // Address map
    ////////////////////

    localparam logic [15:0] RAM_BASE  = 16'h0000;
    localparam logic [15:0] RAM_MASK  = 16'hE000;  // 8 KiB window
    localparam logic [15:0] UART_BASE = 16'hD010;  // four registers
    localparam logic [15:0] ROM_BASE  = 16'hFF00;  // 256 byte monitor

    // UART register offsets
    localparam logic [1:0] UART_KBD   = 2'd0;
    localparam logic [1:0] UART_KBDCR = 2'd1;
    localparam logic [1:0] UART_DSP   = 2'd2;
    localparam logic [1:0] UART_DSPCR = 2'd3;

    // Open bus value
    localparam logic [7:0] UNMAPPED_DATA = 8'hFF;

endpackage

//--- bus_arbiter.sv
// Two masters, one request in flight; a new grant waits until the previous response returns
module bus_arbiter (
    input  logic                       clk25,
    input  logic                       rst_n,
    input  apple1_pkg::bus_req_t [1:0] m_req,
    input  logic [1:0]                 m_req_valid,
    output logic [1:0]                 m_req_ready,
    output apple1_pkg::bus_rsp_t       m_rsp,
    output logic [1:0]                 m_rsp_valid,
    output apple1_pkg::bus_req_t       bus_req,
    output logic                       bus_req_valid,
    input  apple1_pkg::bus_rsp_t       bus_rsp,
    input  logic                       bus_rsp_valid
);
    logic busy;        // request out, reply not yet back
    logic owner;       // master of the request in flight
    logic last_grant;  // round-robin pointer
    logic pick;
    logic accept;

    // Both waiting, the one not served last wins
    always_comb begin
        if (m_req_valid == 2'b11) begin
            pick = ~last_grant;
        end else begin
            pick = m_req_valid[1];
        end
    end

    // Ready follows valid of the picked master only
    assign m_req_ready = busy ? 2'b00 : (m_req_valid & (2'b01 << pick));
    assign accept      = |(m_req_valid & m_req_ready);

    ////////////////////
    // Grant state
    ////////////////////
    always_ff @(posedge clk25) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            owner         <= 1'b0;
            last_grant    <= 1'b1;
            bus_req_valid <= 1'b0;
        end else begin
            bus_req_valid <= accept;
            if (accept) begin
                busy       <= 1'b1;
                owner      <= pick;
                last_grant <= pick;
            end else if (bus_rsp_valid) begin
                busy <= 1'b0;
            end
        end
    end

    // Request payload onto the bus
    always_ff @(posedge clk25) begin
        if (accept) begin
            bus_req <= m_req[pick];
        end
    end

    // Reply data shared, valid steered to owner
    assign m_rsp          = bus_rsp;
    assign m_rsp_valid[0] = bus_rsp_valid & ~owner;
    assign m_rsp_valid[1] = bus_rsp_valid & owner;

endmodule

//--- sys_bus_decoder.sv
// Every target accepts each cycle with a one-cycle read; unclaimed addresses read as 0xFF
module sys_bus_decoder (
    input  logic                        clk25,
    input  logic                        rst_n,
    input  apple1_pkg::bus_req_t        bus_req,
    input  logic                        bus_req_valid,
    output apple1_pkg::bus_rsp_t        bus_rsp,
    output logic                        bus_rsp_valid,
    output logic                        ram_we,
    output logic                        uart_we,
    output logic                        uart_re,
    output logic [15:0]                 tgt_addr,
    output logic [7:0]                  tgt_wdata,
    input  logic [7:0]                  ram_rdata,
    input  logic [7:0]                  rom_rdata,
    input  apple1_pkg::uart_rdata_u     uart_rdata
);
    import apple1_pkg::*;

    typedef enum logic [1:0] {SEL_NONE, SEL_RAM, SEL_UART, SEL_ROM} sel_t;

    logic ram_cs;
    logic uart_cs;
    logic rom_cs;
    sel_t sel_q;

    ////////////////////
    // Address decode
    ////////////////////
    assign ram_cs  = (bus_req.addr & RAM_MASK) == RAM_BASE;
    assign uart_cs = bus_req.addr[15:2] == UART_BASE[15:2];
    assign rom_cs  = bus_req.addr[15:8] == ROM_BASE[15:8];

    // Strobes only in the request cycle
    assign ram_we  = bus_req_valid & bus_req.we & ram_cs;
    assign uart_we = bus_req_valid & bus_req.we & uart_cs;
    assign uart_re = bus_req_valid & ~bus_req.we & uart_cs;

    assign tgt_addr  = bus_req.addr;
    assign tgt_wdata = bus_req.wdata;

    // Remember the target for the read mux
    always_ff @(posedge clk25) begin
        if (!rst_n) begin
            sel_q         <= SEL_NONE;
            bus_rsp_valid <= 1'b0;
        end else begin
            bus_rsp_valid <= bus_req_valid;
            if (bus_req_valid) begin
                if (ram_cs) sel_q <= SEL_RAM;
                else if (uart_cs) sel_q <= SEL_UART;
                else if (rom_cs) sel_q <= SEL_ROM;
                else sel_q <= SEL_NONE;
            end
        end
    end

    // Read data mux, one cycle behind the decode
    always_comb begin
        case (sel_q)
            SEL_RAM:  bus_rsp.rdata = ram_rdata;
            SEL_UART: bus_rsp.rdata = uart_rdata.data;
            SEL_ROM:  bus_rsp.rdata = rom_rdata;
            default:  bus_rsp.rdata = UNMAPPED_DATA;
        endcase
    end

endmodule

//--- ram.sv
// 8 KiB, contents undefined after power-up and untouched by reset
module ram (
    input  logic        clk25,
    input  logic [12:0] addr,
    input  logic        we,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata
);
    logic [7:0] mem [0:8191];

    // Read happens every cycle, old data on a write
    always_ff @(posedge clk25) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- rom_monitor.sv
// 256 bytes read from rom_monitor.hex at start, which must sit in the run directory
module rom_monitor (
    input  logic       clk25,
    input  logic [7:0] addr,
    output logic [7:0] rdata
);
    logic [7:0] mem [0:255];

    // Monitor image
    initial begin
        $readmemh("rom_monitor.hex", mem);
    end

    // Registered read, no write port
    always_ff @(posedge clk25) begin
        rdata <= mem[addr];
    end

endmodule

//--- uart.sv
// 8N1 only with no framing error flag; a DSP write while tx_busy is set is dropped
module uart #(
    parameter int CLKS_PER_BIT = 217
) (
    input  logic                    clk25,
    input  logic                    rst_n,
    input  logic [1:0]              reg_sel,
    input  logic                    we,
    input  logic                    re,
    input  logic [7:0]              wdata,
    output apple1_pkg::uart_rdata_u rdata,
    input  logic                    uart_rx,
    output logic                    uart_tx,
    output logic                    uart_cts
);
    import apple1_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'(CLKS_PER_BIT / 2);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    logic             tx_busy;
    logic [8:0]       tx_shift;  // stop bit above the data
    logic [3:0]       tx_bit;
    logic [CNT_W-1:0] tx_cnt;
    rx_state_t        rx_state;
    logic [1:0]       rx_sync;
    logic             rx_in;
    logic [7:0]       rx_shift;
    logic [7:0]       kbd_data;
    logic [2:0]       rx_bit;
    logic [CNT_W-1:0] rx_cnt;
    logic             rx_ready;

    ////////////////////
    // Transmitter
    ////////////////////
    always_ff @(posedge clk25) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
            uart_tx <= 1'b1;
            tx_bit  <= '0;
            tx_cnt  <= '0;
        end else if (!tx_busy) begin
            if (we && reg_sel == UART_DSP) begin
                // Start bit goes out next cycle
                tx_busy  <= 1'b1;
                uart_tx  <= 1'b0;
                tx_shift <= {1'b1, wdata};
                tx_bit   <= '0;
                tx_cnt   <= '0;
            end
        end else if (tx_cnt == BIT_LAST) begin
            tx_cnt <= '0;
            if (tx_bit == 4'd9) begin
                tx_busy <= 1'b0;  // stop bit done
            end else begin
                uart_tx  <= tx_shift[0];
                tx_shift <= {1'b1, tx_shift[8:1]};
                tx_bit   <= tx_bit + 4'd1;
            end
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    ////////////////////
    // Receiver
    ////////////////////
    assign rx_in = rx_sync[1];

    always_ff @(posedge clk25) begin
        if (!rst_n) begin
            rx_sync  <= 2'b11;
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bit   <= '0;
            rx_ready <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
            // KBD read clears the flag, a new byte wins
            if (re && reg_sel == UART_KBD) begin
                rx_ready <= 1'b0;
            end
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_in) rx_state <= RX_START;
                end
                RX_START: begin
                    // Recheck at mid start bit, glitch goes back to idle
                    if (rx_cnt == BIT_HALF) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_in ? RX_IDLE : RX_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == BIT_LAST) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_in, rx_shift[7:1]};  // LSB first
                        rx_bit   <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7) rx_state <= RX_STOP;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rx_cnt == BIT_LAST) begin
                        rx_state <= RX_IDLE;
                        if (rx_in) begin
                            kbd_data <= rx_shift;
                            rx_ready <= 1'b1;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Host may send while KBD is empty
    assign uart_cts = ~rx_ready;

    // Register read, one cycle latency
    always_ff @(posedge clk25) begin
        case (reg_sel)
            UART_KBD:   rdata.data   <= kbd_data;
            UART_KBDCR: rdata.status <= '{flag: rx_ready, reserved: 7'd0};
            UART_DSP:   rdata.status <= '{flag: tx_busy, reserved: 7'd0};
            UART_DSPCR: rdata.data   <= 8'd0;
            default:    rdata.data   <= 8'd0;
        endcase
    end

endmodule

//--- display_fetcher.sv
// Reads only, one byte per handshake; dropping display_en stops the loop before the next grant
module display_fetcher #(
    parameter logic [15:0] SCREEN_BASE = 16'h0400,
    parameter int          SCREEN_LEN  = 8
) (
    input  logic                 clk25,
    input  logic                 rst_n,
    input  logic                 display_en,
    output apple1_pkg::bus_req_t req,
    output logic                 req_valid,
    input  logic                 req_ready,
    input  apple1_pkg::bus_rsp_t rsp,
    input  logic                 rsp_valid,
    output logic [7:0]           chr,
    output logic                 chr_valid,
    input  logic                 chr_ready
);
    localparam int OFF_W = $clog2(SCREEN_LEN + 1);
    localparam logic [OFF_W-1:0] OFF_LAST = OFF_W'(SCREEN_LEN - 1);

    typedef enum logic [1:0] {ST_REQ, ST_WAIT, ST_PRESENT} state_t;

    state_t           state;
    logic [OFF_W-1:0] offset;

    // Read of the current screen cell
    assign req.addr  = SCREEN_BASE + 16'(offset);
    assign req.wdata = 8'd0;
    assign req.we    = 1'b0;
    assign req_valid = (state == ST_REQ) && display_en;

    assign chr_valid = (state == ST_PRESENT);

    ////////////////////
    // Fetch FSM
    ////////////////////
    always_ff @(posedge clk25) begin
        if (!rst_n) begin
            state  <= ST_REQ;
            offset <= '0;
        end else begin
            case (state)
                ST_REQ: begin
                    if (req_valid && req_ready) state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (rsp_valid) state <= ST_PRESENT;
                end
                default: begin
                    // Hold the byte until the sink takes it
                    if (chr_ready) begin
                        state  <= ST_REQ;
                        offset <= (offset == OFF_LAST) ? '0 : offset + 1'b1;
                    end
                end
            endcase
        end
    end

    // Character latch
    always_ff @(posedge clk25) begin
        if (state == ST_WAIT && rsp_valid) begin
            chr <= rsp.rdata;
        end
    end

endmodule

//--- apple1_soc.sv
// No CPU core inside, the CPU port is a bus master; runs every clk25 cycle with no clock enable
module apple1_soc #(
    parameter int          CLKS_PER_BIT = 217,
    parameter logic [15:0] SCREEN_BASE  = 16'h0400,
    parameter int          SCREEN_LEN   = 8
) (
    input  logic                 clk25,
    input  logic                 rst_n,
    input  apple1_pkg::bus_req_t cpu_req,
    input  logic                 cpu_req_valid,
    output logic                 cpu_req_ready,
    output apple1_pkg::bus_rsp_t cpu_rsp,
    output logic                 cpu_rsp_valid,
    input  logic                 display_en,
    output logic [7:0]           chr,
    output logic                 chr_valid,
    input  logic                 chr_ready,
    input  logic                 uart_rx,
    output logic                 uart_tx,
    output logic                 uart_cts
);
    import apple1_pkg::*;

    bus_req_t    fetch_req;
    logic        fetch_req_valid;
    logic [1:0]  mst_req_ready;
    bus_rsp_t    mst_rsp;
    logic [1:0]  mst_rsp_valid;
    bus_req_t    bus_req;
    logic        bus_req_valid;
    bus_rsp_t    bus_rsp;
    logic        bus_rsp_valid;
    logic        ram_we;
    logic        uart_we;
    logic        uart_re;
    logic [15:0] tgt_addr;
    logic [7:0]  tgt_wdata;
    logic [7:0]  ram_rdata;
    logic [7:0]  rom_rdata;
    uart_rdata_u uart_rdata;

    // Master 0 is the CPU port
    assign cpu_req_ready = mst_req_ready[0];
    assign cpu_rsp       = mst_rsp;
    assign cpu_rsp_valid = mst_rsp_valid[0];

    ////////////////////
    // Masters and bus
    ////////////////////
    bus_arbiter i_bus_arbiter (
        .clk25(clk25), .rst_n(rst_n),
        .m_req({fetch_req, cpu_req}), .m_req_valid({fetch_req_valid, cpu_req_valid}),
        .m_req_ready(mst_req_ready), .m_rsp(mst_rsp), .m_rsp_valid(mst_rsp_valid),
        .bus_req(bus_req), .bus_req_valid(bus_req_valid),
        .bus_rsp(bus_rsp), .bus_rsp_valid(bus_rsp_valid)
    );

    display_fetcher #(.SCREEN_BASE(SCREEN_BASE), .SCREEN_LEN(SCREEN_LEN)) i_display_fetcher (
        .clk25(clk25), .rst_n(rst_n), .display_en(display_en),
        .req(fetch_req), .req_valid(fetch_req_valid), .req_ready(mst_req_ready[1]),
        .rsp(mst_rsp), .rsp_valid(mst_rsp_valid[1]),
        .chr(chr), .chr_valid(chr_valid), .chr_ready(chr_ready)
    );

    sys_bus_decoder i_sys_bus_decoder (
        .clk25(clk25), .rst_n(rst_n),
        .bus_req(bus_req), .bus_req_valid(bus_req_valid),
        .bus_rsp(bus_rsp), .bus_rsp_valid(bus_rsp_valid),
        .ram_we(ram_we), .uart_we(uart_we), .uart_re(uart_re),
        .tgt_addr(tgt_addr), .tgt_wdata(tgt_wdata),
        .ram_rdata(ram_rdata), .rom_rdata(rom_rdata), .uart_rdata(uart_rdata)
    );

    ////////////////////
    // Targets
    ////////////////////
    ram i_ram (
        .clk25(clk25), .addr(tgt_addr[12:0]), .we(ram_we),
        .wdata(tgt_wdata), .rdata(ram_rdata)
    );

    rom_monitor i_rom_monitor (
        .clk25(clk25), .addr(tgt_addr[7:0]), .rdata(rom_rdata)
    );

    uart #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart (
        .clk25(clk25), .rst_n(rst_n), .reg_sel(tgt_addr[1:0]),
        .we(uart_we), .re(uart_re), .wdata(tgt_wdata), .rdata(uart_rdata),
        .uart_rx(uart_rx), .uart_tx(uart_tx), .uart_cts(uart_cts)
    );

endmodule

//--- tb_apple1_soc.sv
// Directed tests of apple1_soc; run from the project root so rom_monitor.hex is found
module tb_apple1_soc;
    timeunit 1ns;
    timeprecision 100ps;

    import apple1_pkg::*;

    localparam int          CLKS_PER_BIT = 8;
    localparam logic [15:0] SCREEN_BASE  = 16'h0400;
    localparam int          SCREEN_LEN   = 8;
    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYC    = 4;
    localparam logic [15:0] SHARE_BASE   = 16'h0800;  // CPU traffic during display

    localparam int N_RAM   = 24;
    localparam int N_CHR   = 2 * SCREEN_LEN + 4;
    localparam int N_SHARE = 8;

    // Worst-case cycle budget per test
    localparam int ACCESS_CYC   = 10;
    localparam int FRAME_CYC    = 10 * CLKS_PER_BIT;
    localparam int RAM_CYC      = 2 * N_RAM * ACCESS_CYC;
    localparam int ROM_CYC      = 260 * ACCESS_CYC;
    localparam int TX_CYC       = 2 * (FRAME_CYC + 4 * ACCESS_CYC);
    localparam int RX_CYC       = 2 * (FRAME_CYC + 6 * ACCESS_CYC);
    localparam int DISP_CYC     = SCREEN_LEN * ACCESS_CYC + N_CHR * (ACCESS_CYC + 8)
                                  + 2 * N_SHARE * ACCESS_CYC;
    localparam int WATCHDOG_CYC = 2 * (RESET_CYC + RAM_CYC + ROM_CYC + TX_CYC + RX_CYC
                                  + DISP_CYC);

    logic        clk25;
    logic        rst_n;
    bus_req_t    cpu_req;
    logic        cpu_req_valid;
    logic        cpu_req_ready;
    bus_rsp_t    cpu_rsp;
    logic        cpu_rsp_valid;
    logic        display_en;
    logic [7:0]  chr;
    logic        chr_valid;
    logic        chr_ready;
    logic        uart_rx;
    logic        uart_tx;
    logic        uart_cts;

    logic [31:0] lcg_state;
    logic [7:0]  shadow [0:8191];   // expected RAM contents
    logic [7:0]  rom_image [0:255];
    logic        stop_seen;         // serial model saw the stop bit
    int          error_count;
    int          check_count;

    apple1_soc #(
        .CLKS_PER_BIT(CLKS_PER_BIT),
        .SCREEN_BASE(SCREEN_BASE),
        .SCREEN_LEN(SCREEN_LEN)
    ) i_apple1_soc (
        .clk25(clk25), .rst_n(rst_n),
        .cpu_req(cpu_req), .cpu_req_valid(cpu_req_valid), .cpu_req_ready(cpu_req_ready),
        .cpu_rsp(cpu_rsp), .cpu_rsp_valid(cpu_rsp_valid),
        .display_en(display_en), .chr(chr), .chr_valid(chr_valid), .chr_ready(chr_ready),
        .uart_rx(uart_rx), .uart_tx(uart_tx), .uart_cts(uart_cts)
    );

    initial clk25 = 1'b0;
    always #(CLK_PERIOD / 2) clk25 = ~clk25;

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    task automatic check_condition(input logic cond, input string msg);
        check_count++;
        if (!cond) report_error(msg);
    endtask

    task automatic compare_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp,
                                input logic [7:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_status(input string name, input uart_status_t exp,
                                  input uart_status_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    ////////////////////
    // CPU port
    ////////////////////

    // Entered and left 1 ns after a rising edge
    task automatic bus_access(input bus_req_t req, output bus_rsp_t rsp);
        int lat;
        cpu_req       = req;
        cpu_req_valid = 1'b1;
        @(negedge clk25);
        while (!cpu_req_ready) @(negedge clk25);
        // Accepted on this edge
        @(posedge clk25);
        #1;
        cpu_req_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk25);
            lat++;
        end while (!cpu_rsp_valid);
        rsp = cpu_rsp;
        // Latency only fixed without the fetcher on the bus
        if (!display_en) begin
            check_condition(lat == 2,
                $sformatf("response to 0x%04h came %0d cycles after acceptance, not 2",
                          req.addr, lat));
        end
        @(posedge clk25);
        #1;
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        bus_rsp_t rsp;
        bus_access(bus_req_t'{addr: addr, wdata: data, we: 1'b1}, rsp);
    endtask

    task automatic bus_read(input logic [15:0] addr, output bus_rsp_t rsp);
        bus_access(bus_req_t'{addr: addr, wdata: 8'd0, we: 1'b0}, rsp);
    endtask

    ////////////////////
    // Serial model
    ////////////////////

    // 8N1, LSB first
    task automatic send_serial(input logic [7:0] data);
        int i;
        uart_rx = 1'b0;
        repeat (CLKS_PER_BIT) @(posedge clk25);
        for (i = 0; i < 8; i++) begin
            #1 uart_rx = data[i];
            repeat (CLKS_PER_BIT) @(posedge clk25);
        end
        #1 uart_rx = 1'b1;
        repeat (CLKS_PER_BIT) @(posedge clk25);
        #1;
    endtask

    task automatic receive_serial(output logic [7:0] data);
        int i;
        @(negedge clk25);
        while (uart_tx) @(negedge clk25);
        // Middle of the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge clk25);
        check_condition(!uart_tx, "uart_tx start bit did not stay low");
        for (i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk25);
            data[i] = uart_tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk25);
        check_condition(uart_tx, "uart_tx stop bit was not high");
        stop_seen = 1'b1;
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic idle_after_reset();
        check_condition(!cpu_req_ready, "cpu_req_ready high after reset");
        check_condition(!cpu_rsp_valid, "cpu_rsp_valid high after reset");
        check_condition(!chr_valid, "chr_valid high after reset");
        check_condition(uart_tx, "uart_tx not idling high after reset");
        check_condition(uart_cts, "uart_cts low after reset");
    endtask

    task automatic ram_readback();
        logic [12:0] addr_q [$];
        logic [31:0] r;
        logic [12:0] a;
        bus_rsp_t    rsp;
        int          i;
        for (i = 0; i < N_RAM; i++) begin
            r = lcg_next();
            a = r[28:16];
            r = lcg_next();
            bus_write({3'b000, a}, r[23:16]);
            shadow[a] = r[23:16];
            addr_q.push_back(a);
        end
        foreach (addr_q[i]) begin
            bus_read({3'b000, addr_q[i]}, rsp);
            compare_rsp($sformatf("ram read 0x%04h", {3'b000, addr_q[i]}),
                        bus_rsp_t'{rdata: shadow[addr_q[i]]}, rsp);
        end
    endtask

    task automatic rom_and_unmapped();
        bus_rsp_t rsp;
        int       i;
        for (i = 0; i < 256; i++) begin
            bus_read(ROM_BASE + 16'(i), rsp);
            compare_rsp($sformatf("rom read 0x%04h", ROM_BASE + 16'(i)),
                        bus_rsp_t'{rdata: rom_image[i]}, rsp);
        end
        bus_read(16'h3000, rsp);
        compare_rsp("unmapped read 0x3000", bus_rsp_t'{rdata: UNMAPPED_DATA}, rsp);
        bus_read(16'hD020, rsp);
        compare_rsp("unmapped read 0xD020", bus_rsp_t'{rdata: UNMAPPED_DATA}, rsp);
        // ROM has no write path
        bus_write(16'hFF10, ~rom_image[8'h10]);
        bus_read(16'hFF10, rsp);
        compare_rsp("rom 0xFF10 after write", bus_rsp_t'{rdata: rom_image[8'h10]}, rsp);
    endtask

    task automatic uart_transmit();
        logic [31:0]  r;
        logic [7:0]   data;
        logic [7:0]   seen;
        bus_rsp_t     rsp;
        uart_status_t st;
        int           n;
        int           polls;
        for (n = 0; n < 2; n++) begin
            r = lcg_next();
            data = r[23:16];
            stop_seen = 1'b0;
            fork
                receive_serial(seen);
                begin
                    bus_write(UART_BASE + UART_DSP, data);
                    bus_read(UART_BASE + UART_DSP, rsp);
                    st = rsp.rdata;
                    compare_status("DSP status after write",
                                   uart_status_t'{flag: 1'b1, reserved: 7'd0}, st);
                    // Poll until the transmitter goes idle
                    polls = 0;
                    do begin
                        bus_read(UART_BASE + UART_DSP, rsp);
                        st = rsp.rdata;
                        polls++;
                    end while (st.flag && polls < FRAME_CYC);
                    check_condition(!st.flag, "DSP busy flag never cleared");
                    check_condition(stop_seen, "DSP busy flag cleared before the stop bit");
                end
            join
            compare_byte("uart_tx byte", data, seen);
        end
    endtask

    task automatic uart_receive();
        logic [31:0]  r;
        logic [7:0]   data;
        bus_rsp_t     rsp;
        uart_status_t st;
        int           n;
        int           polls;
        for (n = 0; n < 2; n++) begin
            r = lcg_next();
            data = r[23:16];
            check_condition(uart_cts, "uart_cts low with KBD empty");
            send_serial(data);
            polls = 0;
            do begin
                bus_read(UART_BASE + UART_KBDCR, rsp);
                st = rsp.rdata;
                polls++;
            end while (!st.flag && polls < FRAME_CYC);
            compare_status("KBDCR after receive",
                           uart_status_t'{flag: 1'b1, reserved: 7'd0}, st);
            check_condition(!uart_cts, "uart_cts stayed high with a byte in KBD");
            bus_read(UART_BASE + UART_KBD, rsp);
            compare_byte("KBD data", data, rsp.rdata);
            bus_read(UART_BASE + UART_KBDCR, rsp);
            st = rsp.rdata;
            compare_status("KBDCR after KBD read",
                           uart_status_t'{flag: 1'b0, reserved: 7'd0}, st);
            check_condition(uart_cts, "uart_cts still low after KBD was read");
        end
    endtask

    // Sink with random stalls, only caller of the LCG inside the fork
    task automatic collect_chars();
        logic [31:0] r;
        logic [12:0] a;
        int          idx;
        int          hold;
        idx  = 0;
        hold = 0;
        while (idx < N_CHR) begin
            chr_ready = (hold == 0);
            if (hold > 0) hold--;
            @(negedge clk25);
            if (chr_valid && chr_ready) begin
                a = SCREEN_BASE[12:0] + 13'(idx % SCREEN_LEN);
                compare_byte($sformatf("chr %0d", idx), shadow[a], chr);
                idx++;
                r = lcg_next();
                hold = int'(r[31:29]);
            end
            @(posedge clk25);
            #1;
        end
        chr_ready = 1'b1;
    endtask

    task automatic display_sharing();
        logic [7:0]  cpu_data [N_SHARE];
        logic [31:0] r;
        int          i;
        // Screen contents, written before the fetcher runs
        for (i = 0; i < SCREEN_LEN; i++) begin
            r = lcg_next();
            bus_write(SCREEN_BASE + 16'(i), r[23:16]);
            shadow[SCREEN_BASE[12:0] + 13'(i)] = r[23:16];
        end
        for (i = 0; i < N_SHARE; i++) begin
            r = lcg_next();
            cpu_data[i] = r[23:16];
        end
        display_en = 1'b1;
        fork
            collect_chars();
            begin : cpu_traffic
                bus_rsp_t rsp;
                int       k;
                for (k = 0; k < N_SHARE; k++) begin
                    bus_write(SHARE_BASE + 16'(k), cpu_data[k]);
                    shadow[SHARE_BASE[12:0] + 13'(k)] = cpu_data[k];
                    bus_read(SHARE_BASE + 16'(k), rsp);
                    compare_rsp($sformatf("shared ram read 0x%04h", SHARE_BASE + 16'(k)),
                                bus_rsp_t'{rdata: cpu_data[k]}, rsp);
                end
            end
        join
        display_en = 1'b0;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        rst_n         = 1'b0;
        cpu_req       = '0;
        cpu_req_valid = 1'b0;
        display_en    = 1'b0;
        chr_ready     = 1'b0;
        uart_rx       = 1'b1;
        lcg_state     = 32'hbbe2;
        stop_seen     = 1'b0;
        error_count   = 0;
        check_count   = 0;
        $readmemh("rom_monitor.hex", rom_image);
        repeat (RESET_CYC) @(posedge clk25);
        #1 rst_n = 1'b1;
        idle_after_reset();
        ram_readback();
        rom_and_unmapped();
        uart_transmit();
        uart_receive();
        display_sharing();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog, budget is twice the summed worst case
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Testbench failed");
        $finish;
    end

endmodule

//--- rom_monitor.hex
// Monitor ROM image, one byte per entry from 0xFF00 upward, 32 entries per line
// Fill is the inverted low address byte
FF FE FD FC FB FA F9 F8 F7 F6 F5 F4 F3 F2 F1 F0 EF EE ED EC EB EA E9 E8 E7 E6 E5 E4 E3 E2 E1 E0
DF DE DD DC DB DA D9 D8 D7 D6 D5 D4 D3 D2 D1 D0 CF CE CD CC CB CA C9 C8 C7 C6 C5 C4 C3 C2 C1 C0
BF BE BD BC BB BA B9 B8 B7 B6 B5 B4 B3 B2 B1 B0 AF AE AD AC AB AA A9 A8 A7 A6 A5 A4 A3 A2 A1 A0
9F 9E 9D 9C 9B 9A 99 98 97 96 95 94 93 92 91 90 8F 8E 8D 8C 8B 8A 89 88 87 86 85 84 83 82 81 80
7F 7E 7D 7C 7B 7A 79 78 77 76 75 74 73 72 71 70 6F 6E 6D 6C 6B 6A 69 68 67 66 65 64 63 62 61 60
5F 5E 5D 5C 5B 5A 59 58 57 56 55 54 53 52 51 50 4F 4E 4D 4C 4B 4A 49 48 47 46 45 44 43 42 41 40
3F 3E 3D 3C 3B 3A 39 38 37 36 35 34 33 32 31 30 2F 2E 2D 2C 2B 2A 29 28 27 26 25 24 23 22 21 20
1F 1E 1D 1C 1B 1A 19 18 17 16 15 14 13 12 11 10 0F 0E 0D 0C 0B 0A 09 08 07 06 05 04 03 02 01 00

//--- vlog.f
apple1_pkg.sv
bus_arbiter.sv
sys_bus_decoder.sv
ram.sv
rom_monitor.sv
uart.sv
display_fetcher.sv
apple1_soc.sv
tb_apple1_soc.sv

//--- Bender.yml
package:
  name: apple1_soc

sources:
  - apple1_pkg.sv
  - bus_arbiter.sv
  - sys_bus_decoder.sv
  - ram.sv
  - rom_monitor.sv
  - uart.sv
  - display_fetcher.sv
  - apple1_soc.sv
  - target: test
    files:
      - tb_apple1_soc.sv
